// File: Makefile
# Verilator build and run for the lookup request arbiter testbench

VERILATOR ?= verilator
TOP       ?= tbTlbReqArbiter
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, check the log for the pass line"
	@echo "  clean  remove build output and the log"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: design/arbOutputStage.sv
// ====================
// Winner payload mux and the single output register
// Output trails the grant by exactly one cycle
// ====================

`timescale 1ns/1ns
`default_nettype none

`include "tlbArb_settings.svh"

module arbOutputStage (
   input  logic                 clk,
   input  logic                 rstN,
   input  tlbArbPkg::srcVecT    gntVec,
   input  tlbArbPkg::tlbIdT     invTlbId,
   input  tlbArbPkg::pageAddrT  invAddr,
   input  tlbArbPkg::tlbIdT     fillTlbId,
   input  tlbArbPkg::pageAddrT  fillAddr,
   input  tlbArbPkg::tlbIdT     pendQTlbId,
   input  tlbArbPkg::pageAddrT  pendQAddr,
   input  tlbArbPkg::tlbOpcodeT pendQOpcode,
   input  tlbArbPkg::tlbIdT     cbHiTlbId,
   input  tlbArbPkg::pageAddrT  cbHiAddr,
   input  tlbArbPkg::tlbOpcodeT cbHiOpcode,
   input  tlbArbPkg::tlbIdT     cbLoTlbId,
   input  tlbArbPkg::pageAddrT  cbLoAddr,
   input  tlbArbPkg::tlbOpcodeT cbLoOpcode,
   output logic                 outValid,
   output tlbArbPkg::srcVecT    outSrc,
   output tlbArbPkg::tlbIdT     outTlbId,
   output tlbArbPkg::pageAddrT  outAddr,
   output tlbArbPkg::tlbOpcodeT outOpcode
);
   import tlbArbPkg::*;

   tlbIdT     selTlbId;
   pageAddrT  selAddr;
   tlbOpcodeT selOpcode;

   // Grant is one-hot, invalidation is the fallthrough
   always_comb begin
      selTlbId  = invTlbId;
      selAddr   = invAddr;
      selOpcode = opInval;
      if (gntVec[srcFill]) begin
         selTlbId  = fillTlbId;
         selAddr   = fillAddr;
         selOpcode = opFill;
      end else if (gntVec[srcPendQ]) begin
         selTlbId  = pendQTlbId;
         selAddr   = pendQAddr;
         selOpcode = pendQOpcode;
      end else if (gntVec[srcCbHi]) begin
         selTlbId  = cbHiTlbId;
         selAddr   = cbHiAddr;
         selOpcode = cbHiOpcode;
      end else if (gntVec[srcCbLo]) begin
         selTlbId  = cbLoTlbId;
         selAddr   = cbLoAddr;
         selOpcode = cbLoOpcode;
      end
   end

   // ====================
   // Output register

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         outValid <= 1'b0;
         outSrc   <= '0;
      end else begin
         outValid <= |gntVec;
         outSrc   <= gntVec;
      end
   end

   // Payload only loads on a grant
   always_ff @(posedge clk) begin
      if (|gntVec) begin
         outTlbId  <= selTlbId;
         outAddr   <= selAddr;
         outOpcode <= selOpcode;
      end
   end

   // Next cycle carries one source, with the forced opcodes for inv and fill
   outFollowsGntA : assert property (@(posedge clk) disable iff (!rstN)
      (|gntVec) |=> (outValid && $onehot(outSrc)
                     && (!outSrc[srcInv] || (outOpcode == opInval))
                     && (!outSrc[srcFill] || (outOpcode == opFill))));

endmodule

`default_nettype wire

// File: design/missCreditTracker.sv
// ====================
// Miss FIFO credit pool for the three translation sources
// Direct returns land at once, response returns drain one per cycle
// ====================

`timescale 1ns/1ns
`default_nettype none

`include "tlbArb_settings.svh"

module missCreditTracker (
   input  logic              clk,
   input  logic              rstN,
   input  tlbArbPkg::srcVecT gntVec,
   input  logic              msfifoCrdRet,
   input  logic              respCrdRet,
   output logic              xreqReady
);
   import tlbArbPkg::*;

   // Current credits and deferred returns
   creditT crdCnt;
   creditT accCnt;
   creditT crdNxt;
   creditT accNxt;

   logic   xreqGranted;
   logic   accDrain;
   logic   crdInc;

   // ====================
   // Next state

   always_comb begin
      // Any translation grant consumes a miss FIFO slot
      xreqGranted = gntVec[srcPendQ] | gntVec[srcCbHi] | gntVec[srcCbLo];

      // Deferred path only moves a credit when the direct path is idle
      accDrain = !msfifoCrdRet && (accCnt != '0);
      crdInc   = msfifoCrdRet || accDrain;

      accNxt = accCnt;
      if (respCrdRet && !accDrain) begin
         accNxt = accCnt + creditT'(1);
      end else if (!respCrdRet && accDrain) begin
         accNxt = accCnt - creditT'(1);
      end

      // Grant and return in one cycle cancel out
      crdNxt = crdCnt;
      if (crdInc && !xreqGranted) begin
         crdNxt = crdCnt + creditT'(1);
      end else if (!crdInc && xreqGranted) begin
         crdNxt = crdCnt - creditT'(1);
      end
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         crdCnt <= creditT'(`TLBARB_MISS_DEPTH);
         accCnt <= '0;
      end else begin
         crdCnt <= crdNxt;
         accCnt <= accNxt;
      end
   end

   // Registered count, so a change shows up one cycle later
   assign xreqReady = (crdCnt != '0);

   // ====================
   // Checks

   crdBoundA : assert property (@(posedge clk) disable iff (!rstN)
      crdCnt <= creditT'(`TLBARB_MISS_DEPTH));

   // Arbiter must honour xreqReady
   noGntWithoutCrdA : assert property (@(posedge clk) disable iff (!rstN)
      xreqGranted |-> (crdCnt != '0));

endmodule

`default_nettype wire

// File: design/tlbArbPkg.sv
// ====================
// Shared types for the lookup request arbiter
// Modules import it inside their bodies
// ====================

`default_nettype none

`include "tlbArb_settings.svh"

package tlbArbPkg;

   // ====================
   // Payload fields

   // Array identifier
   typedef logic [`TLBARB_TLBID_W-1:0] tlbIdT;

   // Page number
   typedef logic [`TLBARB_ADDR_W-1:0] pageAddrT;

   // Back-to-back grant limit per source
   typedef logic [`TLBARB_GCNT_W-1:0] grantCntT;

   // Holds 0 up to the full FIFO depth
   typedef logic [$clog2(`TLBARB_MISS_DEPTH):0] creditT;

   // ====================
   // Sources

   // One bit per source, bit 0 is invalidation
   typedef logic [`TLBARB_NUM_SRC-1:0] srcVecT;

   // Index into srcVecT
   typedef logic [$clog2(`TLBARB_NUM_SRC)-1:0] srcIdxT;

   localparam srcIdxT srcInv   = 3'd0;
   localparam srcIdxT srcFill  = 3'd1;
   localparam srcIdxT srcPendQ = 3'd2;
   localparam srcIdxT srcCbHi  = 3'd3;
   localparam srcIdxT srcCbLo  = 3'd4;

   // Lookup pipeline operation
   typedef enum logic [1:0] {
      opTranslate  = 2'd0,
      opUarchInval = 2'd1,
      opFill       = 2'd2,
      opInval      = 2'd3
   } tlbOpcodeT;

endpackage

`default_nettype wire

// File: design/tlbConflictFilter.sv
// ====================
// Request masking against an array write in flight
// Invalidation requests always pass
// ====================

`timescale 1ns/1ns
`default_nettype none

`include "tlbArb_settings.svh"

module tlbConflictFilter (
   input  logic              invPipeV,
   input  logic              fillPipeV,
   input  logic              pendQPipeV,
   input  logic              cbHiPipeV,
   input  logic              cbLoPipeV,
   input  tlbArbPkg::tlbIdT  fillTlbId,
   input  tlbArbPkg::tlbIdT  pendQTlbId,
   input  tlbArbPkg::tlbIdT  cbHiTlbId,
   input  tlbArbPkg::tlbIdT  cbLoTlbId,
   input  logic              blkValid,
   input  logic              blkIsFill,
   input  logic              blkIsInval,
   input  logic              invBlockDma,
   input  tlbArbPkg::tlbIdT  blkTlbId,
   output tlbArbPkg::srcVecT reqVec
);
   import tlbArbPkg::*;

   // Write in progress that a read could collide with
   logic blkAnyWrite;
   // Eviction style write, also unsafe for a fill
   logic blkInvWrite;

   logic pendQHit;
   logic cbHiHit;
   logic cbLoHit;
   logic fillHit;

   always_comb begin
      blkAnyWrite = blkValid && (blkIsFill || blkIsInval);
      blkInvWrite = blkValid && blkIsInval;

      // Same array as the pending write
      pendQHit = blkAnyWrite && (pendQTlbId == blkTlbId);
      cbHiHit  = blkAnyWrite && (cbHiTlbId == blkTlbId);
      cbLoHit  = blkAnyWrite && (cbLoTlbId == blkTlbId);
      fillHit  = blkInvWrite && (fillTlbId == blkTlbId);
   end

   // ====================
   // Filtered request vector

   always_comb begin
      reqVec = '0;

      // Invalidation is never held back
      reqVec[srcInv]   = invPipeV;
      reqVec[srcFill]  = fillPipeV && !fillHit;

      // DMA block from the invalidation engine stops all translations
      reqVec[srcPendQ] = pendQPipeV && !(invBlockDma || pendQHit);
      reqVec[srcCbHi]  = cbHiPipeV && !(invBlockDma || cbHiHit);
      reqVec[srcCbLo]  = cbLoPipeV && !(invBlockDma || cbLoHit);
   end

endmodule

`default_nettype wire

// File: design/tlbReqArbiter.sv
// ====================
// Lookup pipeline request arbiter, top level
// Credit tracker and conflict filter feed the weighted arbiter
// ====================

`timescale 1ns/1ns
`default_nettype none

`include "tlbArb_settings.svh"

module tlbReqArbiter (
   input  logic                 clk,
   input  logic                 rstN,
   // Invalidation
   input  logic                 invPipeV,
   input  tlbArbPkg::tlbIdT     invTlbId,
   input  tlbArbPkg::pageAddrT  invAddr,
   output logic                 invGnt,
   // Fill
   input  logic                 fillPipeV,
   input  tlbArbPkg::tlbIdT     fillTlbId,
   input  tlbArbPkg::pageAddrT  fillAddr,
   output logic                 fillGnt,
   // Pending queue replay
   input  logic                 pendQPipeV,
   input  tlbArbPkg::tlbIdT     pendQTlbId,
   input  tlbArbPkg::pageAddrT  pendQAddr,
   input  tlbArbPkg::tlbOpcodeT pendQOpcode,
   output logic                 pendQGnt,
   // New requests, high and low priority
   input  logic                 cbHiPipeV,
   input  tlbArbPkg::tlbIdT     cbHiTlbId,
   input  tlbArbPkg::pageAddrT  cbHiAddr,
   input  tlbArbPkg::tlbOpcodeT cbHiOpcode,
   output logic                 cbHiGnt,
   input  logic                 cbLoPipeV,
   input  tlbArbPkg::tlbIdT     cbLoTlbId,
   input  tlbArbPkg::pageAddrT  cbLoAddr,
   input  tlbArbPkg::tlbOpcodeT cbLoOpcode,
   output logic                 cbLoGnt,
   // Grant counts
   input  tlbArbPkg::grantCntT  fillGCnt,
   input  tlbArbPkg::grantCntT  pendQGCnt,
   input  tlbArbPkg::grantCntT  hiGCnt,
   input  tlbArbPkg::grantCntT  loGCnt,
   // Credit returns
   input  logic                 msfifoCrdRet,
   input  logic                 respCrdRet,
   // Array write and DMA blocking
   input  logic                 blkValid,
   input  tlbArbPkg::tlbIdT     blkTlbId,
   input  logic                 blkIsFill,
   input  logic                 blkIsInval,
   input  logic                 invBlockDma,
   // To the lookup pipeline
   output logic                 outValid,
   output tlbArbPkg::srcVecT    outSrc,
   output tlbArbPkg::tlbIdT     outTlbId,
   output tlbArbPkg::pageAddrT  outAddr,
   output tlbArbPkg::tlbOpcodeT outOpcode
);
   import tlbArbPkg::*;

   srcVecT reqVec;
   srcVecT gntVec;
   logic   xreqReady;

   missCreditTracker uCrd (
      .clk(clk), .rstN(rstN), .gntVec(gntVec),
      .msfifoCrdRet(msfifoCrdRet), .respCrdRet(respCrdRet), .xreqReady(xreqReady)
   );

   tlbConflictFilter uFilt (
      .invPipeV(invPipeV), .fillPipeV(fillPipeV), .pendQPipeV(pendQPipeV),
      .cbHiPipeV(cbHiPipeV), .cbLoPipeV(cbLoPipeV),
      .fillTlbId(fillTlbId), .pendQTlbId(pendQTlbId),
      .cbHiTlbId(cbHiTlbId), .cbLoTlbId(cbLoTlbId),
      .blkValid(blkValid), .blkIsFill(blkIsFill), .blkIsInval(blkIsInval),
      .invBlockDma(invBlockDma), .blkTlbId(blkTlbId), .reqVec(reqVec)
   );

   weightedRrArbiter uArb (
      .clk(clk), .rstN(rstN), .reqVec(reqVec), .xreqReady(xreqReady),
      .fillGCnt(fillGCnt), .pendQGCnt(pendQGCnt), .hiGCnt(hiGCnt), .loGCnt(loGCnt),
      .gntVec(gntVec)
   );

   arbOutputStage uOut (
      .clk(clk), .rstN(rstN), .gntVec(gntVec),
      .invTlbId(invTlbId), .invAddr(invAddr),
      .fillTlbId(fillTlbId), .fillAddr(fillAddr),
      .pendQTlbId(pendQTlbId), .pendQAddr(pendQAddr), .pendQOpcode(pendQOpcode),
      .cbHiTlbId(cbHiTlbId), .cbHiAddr(cbHiAddr), .cbHiOpcode(cbHiOpcode),
      .cbLoTlbId(cbLoTlbId), .cbLoAddr(cbLoAddr), .cbLoOpcode(cbLoOpcode),
      .outValid(outValid), .outSrc(outSrc), .outTlbId(outTlbId),
      .outAddr(outAddr), .outOpcode(outOpcode)
   );

   // Grants go back to the sources in the same cycle
   assign invGnt   = gntVec[srcInv];
   assign fillGnt  = gntVec[srcFill];
   assign pendQGnt = gntVec[srcPendQ];
   assign cbHiGnt  = gntVec[srcCbHi];
   assign cbLoGnt  = gntVec[srcCbLo];

endmodule

`default_nettype wire

// File: design/weightedRrArbiter.sv
// ====================
// Weighted round-robin over the five filtered requests
// Owner may hold the slot for up to its grant count
// ====================

`timescale 1ns/1ns
`default_nettype none

`include "tlbArb_settings.svh"

module weightedRrArbiter (
   input  logic                clk,
   input  logic                rstN,
   input  tlbArbPkg::srcVecT   reqVec,
   input  logic                xreqReady,
   input  tlbArbPkg::grantCntT fillGCnt,
   input  tlbArbPkg::grantCntT pendQGCnt,
   input  tlbArbPkg::grantCntT hiGCnt,
   input  tlbArbPkg::grantCntT loGCnt,
   output tlbArbPkg::srcVecT   gntVec
);
   import tlbArbPkg::*;

   // Last winner and how many grants it took in a row
   srcIdxT   owner;
   grantCntT runCnt;

   grantCntT gCnt [`TLBARB_NUM_SRC];
   srcVecT   eligible;
   logic     keepOwner;
   logic     gntFound;
   srcIdxT   gntIdx;

   // Cyclic step upward from base
   function automatic srcIdxT nextIdx(input srcIdxT base, input int step);
      int sum;
      sum = int'(base) + step;
      if (sum >= `TLBARB_NUM_SRC) begin
         sum = sum - `TLBARB_NUM_SRC;
      end
      return srcIdxT'(sum);
   endfunction

   always_comb begin
      gCnt[srcInv]   = grantCntT'(`TLBARB_INV_GCNT);
      gCnt[srcFill]  = fillGCnt;
      gCnt[srcPendQ] = pendQGCnt;
      gCnt[srcCbHi]  = hiGCnt;
      gCnt[srcCbLo]  = loGCnt;
   end

   // ====================
   // Grant selection

   always_comb begin
      eligible = reqVec;
      // No miss FIFO slot, so translations sit out
      if (!xreqReady) begin
         eligible[srcPendQ] = 1'b0;
         eligible[srcCbHi]  = 1'b0;
         eligible[srcCbLo]  = 1'b0;
      end

      keepOwner = eligible[owner] && (runCnt < gCnt[owner]);
      gntFound  = keepOwner;
      gntIdx    = owner;

      // Search after the owner, the owner itself comes last
      if (!keepOwner) begin
         for (int k = 1; k <= `TLBARB_NUM_SRC; k++) begin
            if (!gntFound && eligible[nextIdx(owner, k)]) begin
               gntFound = 1'b1;
               gntIdx   = nextIdx(owner, k);
            end
         end
      end

      gntVec = '0;
      if (gntFound) begin
         gntVec[gntIdx] = 1'b1;
      end
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         // Saturated run on the last index, so the first search starts at 0
         owner  <= srcCbLo;
         runCnt <= '1;
      end else if (gntFound) begin
         owner  <= gntIdx;
         runCnt <= keepOwner ? runCnt + grantCntT'(1) : grantCntT'(1);
      end
   end

   // ====================
   // Checks

   gntOneHotA : assert property (@(posedge clk) disable iff (!rstN)
      $onehot0(gntVec) && ((gntVec & ~reqVec) == '0));

   // Grant counts come from configuration outside the arbiter
   gCntNonZeroA : assert property (@(posedge clk) disable iff (!rstN)
      (fillGCnt != '0) && (pendQGCnt != '0) && (hiGCnt != '0) && (loGCnt != '0));

endmodule

`default_nettype wire

// File: flist.f
+incdir+include
design/tlbArbPkg.sv
design/missCreditTracker.sv
design/tlbConflictFilter.sv
design/weightedRrArbiter.sv
design/arbOutputStage.sv
design/tlbReqArbiter.sv
testbench/tbClockGen.sv
testbench/tbTlbReqArbiter.sv

// File: include/tlbArb_settings.svh
// ====================
// Build constants for the lookup request arbiter
// Included by the package, the RTL and the testbench
// ====================

`ifndef TLBARB_SETTINGS_SVH
`define TLBARB_SETTINGS_SVH

// ====================
// Payload widths

// Array identifier
`define TLBARB_TLBID_W 4

// Page number field
`define TLBARB_ADDR_W 20

// ====================
// Arbitration

// Width of one grant count
`define TLBARB_GCNT_W 3

// Fixed run length for invalidation
`define TLBARB_INV_GCNT 4

// Sources in index order inv, fill, pendQ, cbHi, cbLo
`define TLBARB_NUM_SRC 5

// ====================
// Miss FIFO

// Credits available after reset
`define TLBARB_MISS_DEPTH 8

`endif

// File: testbench/tbClockGen.sv
// ====================
// Testbench clock and reset source
// 10 ns clock, reset held low for a fixed number of cycles
// ====================

`timescale 1ns/1ns
`default_nettype none

module tbClockGen #(
   parameter int RESET_CYCLES = 16
) (
   output logic clk,
   output logic rstN
);
   initial begin
      clk = 1'b0;
      forever begin
         #5 clk = ~clk;
      end
   end

   // Release on a rising edge after the reset window
   initial begin
      rstN = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      rstN <= 1'b1;
   end

endmodule

`default_nettype wire

// File: testbench/tbTlbReqArbiter.sv
// ====================
// Testbench for the lookup request arbiter
// Drives the five sources, models grants and credits, checks every cycle
// ====================

`timescale 1ns/1ns
`default_nettype none

`include "tlbArb_settings.svh"

module tbTlbReqArbiter;
   import tlbArbPkg::*;

   localparam int DEPTH   = `TLBARB_MISS_DEPTH;
   localparam int TIMEOUT = 200;

   logic clk;
   logic rstN;

   // Source side, index 0 is invalidation
   srcVecT    pV;
   tlbIdT     pId [5];
   pageAddrT  pAddr [5];
   tlbOpcodeT pOp [5];
   grantCntT  gcFill, gcPendQ, gcHi, gcLo;
   logic      msfifoCrdRet, respCrdRet;
   logic      blkValid, blkIsFill, blkIsInval, invBlockDma;
   tlbIdT     blkTlbId;

   logic invGnt, fillGnt, pendQGnt, cbHiGnt, cbLoGnt;
   logic outValid;
   srcVecT outSrc;
   tlbIdT outTlbId;
   pageAddrT outAddr;
   tlbOpcodeT outOpcode;

   // Reference model state, updated at each falling edge for the next rising edge
   int mOwner, mRun, mCrd, mAcc;
   logic prevValid;
   srcVecT prevSrc;
   tlbIdT prevId;
   pageAddrT prevAddr;
   tlbOpcodeT prevOp;

   srcVecT gntSeen;
   int gntCount [5];
   int gntLog [$];
   int errCount;
   integer seed;

   // Stimulus modes
   srcVecT keepMask;
   logic echoRet;
   logic fixIds;

   tbClockGen clkGen (.clk(clk), .rstN(rstN));

   tlbReqArbiter UUT (
      .clk(clk), .rstN(rstN),
      .invPipeV(pV[0]), .invTlbId(pId[0]), .invAddr(pAddr[0]), .invGnt(invGnt),
      .fillPipeV(pV[1]), .fillTlbId(pId[1]), .fillAddr(pAddr[1]), .fillGnt(fillGnt),
      .pendQPipeV(pV[2]), .pendQTlbId(pId[2]), .pendQAddr(pAddr[2]),
      .pendQOpcode(pOp[2]), .pendQGnt(pendQGnt),
      .cbHiPipeV(pV[3]), .cbHiTlbId(pId[3]), .cbHiAddr(pAddr[3]),
      .cbHiOpcode(pOp[3]), .cbHiGnt(cbHiGnt),
      .cbLoPipeV(pV[4]), .cbLoTlbId(pId[4]), .cbLoAddr(pAddr[4]),
      .cbLoOpcode(pOp[4]), .cbLoGnt(cbLoGnt),
      .fillGCnt(gcFill), .pendQGCnt(gcPendQ), .hiGCnt(gcHi), .loGCnt(gcLo),
      .msfifoCrdRet(msfifoCrdRet), .respCrdRet(respCrdRet),
      .blkValid(blkValid), .blkTlbId(blkTlbId), .blkIsFill(blkIsFill),
      .blkIsInval(blkIsInval), .invBlockDma(invBlockDma),
      .outValid(outValid), .outSrc(outSrc), .outTlbId(outTlbId),
      .outAddr(outAddr), .outOpcode(outOpcode)
   );

   // ====================
   // Helpers

   task automatic checkVal(input string what, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         errCount++;
         $display("MISMATCH at %0t ns: %s got %0h expected %0h", $time, what, got, exp);
         $display("Result: FAILED");
         $fatal(1, "stopping at first mismatch");
      end
   endtask

   task automatic failRun(input string why);
      $display("Error at %0t ns: %s", $time, why);
      $display("Result: FAILED");
      $fatal(1, "run aborted");
   endtask

   function automatic tlbIdT randId();
      return tlbIdT'($random(seed) & 3);
   endfunction

   function automatic tlbOpcodeT randOp();
      int r;
      r = $random(seed) & 3;
      case (r)
         0: return opTranslate;
         1: return opUarchInval;
         2: return opFill;
         default: return opInval;
      endcase
   endfunction

   function automatic grantCntT randGCnt();
      int r;
      r = (($random(seed) & 32'h7fffffff) % 7) + 1;
      return grantCntT'(r);
   endfunction

   function automatic int gcOf(input int idx);
      case (idx)
         0: return `TLBARB_INV_GCNT;
         1: return int'(gcFill);
         2: return int'(gcPendQ);
         3: return int'(gcHi);
         default: return int'(gcLo);
      endcase
   endfunction

   // Valid requests left after write conflicts and the DMA block
   function automatic srcVecT filterReq();
      srcVecT r;
      logic anyW;
      logic invW;
      anyW = blkValid && (blkIsFill || blkIsInval);
      invW = blkValid && blkIsInval;
      r[0] = pV[0];
      r[1] = pV[1] && !(invW && (pId[1] == blkTlbId));
      for (int s = 2; s < 5; s++) begin
         r[s] = pV[s] && !invBlockDma && !(anyW && (pId[s] == blkTlbId));
      end
      return r;
   endfunction

   // Expected winner index, or -1 when nobody is granted
   function automatic int refGrant(input srcVecT req, input int crd, input int own,
                                   input int run);
      srcVecT elig;
      int idx;
      elig = req;
      if (crd == 0) begin
         elig[4:2] = 3'b000;
      end
      if (elig[own] && (run < gcOf(own))) begin
         return own;
      end
      for (int k = 1; k <= 5; k++) begin
         idx = (own + k) % 5;
         if (elig[idx]) begin
            return idx;
         end
      end
      return -1;
   endfunction

   // ====================
   // Compare process

   always @(negedge clk) begin
      int g;
      srcVecT expVec;
      srcVecT dutVec;
      logic drain;
      if (!rstN) begin
         mOwner = 4;
         mRun = 7;
         mCrd = DEPTH;
         mAcc = 0;
         prevValid = 1'b0;
         gntSeen = '0;
      end else begin
         g = refGrant(filterReq(), mCrd, mOwner, mRun);
         expVec = '0;
         if (g >= 0) begin
            expVec[g] = 1'b1;
         end
         dutVec = {cbLoGnt, cbHiGnt, pendQGnt, fillGnt, invGnt};
         checkVal("grant vector", 32'(dutVec), 32'(expVec));
         checkVal("outValid", 32'(outValid), 32'(prevValid));
         if (prevValid) begin
            checkVal("outSrc", 32'(outSrc), 32'(prevSrc));
            checkVal("outTlbId", 32'(outTlbId), 32'(prevId));
            checkVal("outAddr", 32'(outAddr), 32'(prevAddr));
            checkVal("outOpcode", 32'(outOpcode), 32'(prevOp));
         end
         gntSeen = dutVec;
         prevValid = (g >= 0);
         prevSrc = expVec;
         if (g >= 0) begin
            gntCount[g]++;
            gntLog.push_back(g);
            prevId = pId[g];
            prevAddr = pAddr[g];
            prevOp = (g == 0) ? opInval : (g == 1) ? opFill : pOp[g];
            // Owner repeats only while under its grant count
            mRun = (g == mOwner && mRun < gcOf(mOwner)) ? mRun + 1 : 1;
            mOwner = g;
         end
         drain = !msfifoCrdRet && (mAcc != 0);
         mCrd = mCrd + ((msfifoCrdRet || drain) ? 1 : 0) - ((g >= 2) ? 1 : 0);
         mAcc = mAcc + (respCrdRet ? 1 : 0) - (drain ? 1 : 0);
      end
   end

   // ====================
   // Stimulus

   // One cycle: granted sources move on, translation grants echo a credit
   task automatic stepCycle();
      @(posedge clk);
      for (int s = 0; s < 5; s++) begin
         if (gntSeen[s]) begin
            pV[s] <= keepMask[s];
            if (!fixIds) begin
               pId[s] <= randId();
            end
            pAddr[s] <= pageAddrT'($random(seed));
            pOp[s] <= randOp();
         end
      end
      msfifoCrdRet <= echoRet && (gntSeen[4:2] != 3'b000);
      respCrdRet <= 1'b0;
   endtask

   task automatic waitGnt(input int idx);
      int n;
      n = 0;
      while (!gntSeen[idx]) begin
         stepCycle();
         n++;
         if (n > TIMEOUT) begin
            failRun($sformatf("no grant for source %0d", idx));
         end
      end
   endtask

   // Idle until every credit is home
   task automatic waitCreditsFull();
      int n;
      n = 0;
      while (mCrd != DEPTH) begin
         stepCycle();
         if (mCrd + mAcc < DEPTH) begin
            respCrdRet <= 1'b1;
         end
         n++;
         if (n > TIMEOUT) begin
            failRun("credits never returned to full depth");
         end
      end
   endtask

   task automatic clearCounts();
      for (int s = 0; s < 5; s++) begin
         gntCount[s] = 0;
      end
   endtask

   initial begin
      int n;
      int outstanding;
      int r;
      int pattern [12];
      seed = 14150;
      errCount = 0;
      pattern = '{0, 0, 0, 0, 1, 1, 2, 3, 3, 3, 4, 4};
      pV = '0;
      for (int s = 0; s < 5; s++) begin
         pId[s] = tlbIdT'(s);
         pAddr[s] = pageAddrT'(32'h100 * s);
         pOp[s] = opTranslate;
      end
      gcFill = 3'd2;
      gcPendQ = 3'd1;
      gcHi = 3'd3;
      gcLo = 3'd2;
      msfifoCrdRet = 1'b0;
      respCrdRet = 1'b0;
      blkValid = 1'b0;
      blkTlbId = '0;
      blkIsFill = 1'b0;
      blkIsInval = 1'b0;
      invBlockDma = 1'b0;
      keepMask = '1;
      echoRet = 1'b1;
      fixIds = 1'b0;
      clearCounts();

      n = 0;
      while (!rstN) begin
         @(posedge clk);
         n++;
         if (n > TIMEOUT) begin
            failRun("reset never released");
         end
      end

      // Weighted rotation with every source busy
      @(posedge clk);
      pV <= '1;
      gntLog.delete();
      repeat (24) stepCycle();
      for (int i = 0; i < 24; i++) begin
         checkVal("rotation order", 32'(gntLog[i]), 32'(pattern[i % 12]));
      end

      // cbLo alone drains the credit pool
      keepMask = '0;
      stepCycle();
      pV <= '0;
      waitCreditsFull();
      echoRet = 1'b0;
      keepMask = 5'b10000;
      @(posedge clk);
      pV[4] <= 1'b1;
      clearCounts();
      repeat (30) stepCycle();
      checkVal("cbLo grants on full pool", 32'(gntCount[4]), 32'(DEPTH));
      pV[0] <= 1'b1;
      pV[1] <= 1'b1;
      waitGnt(0);
      waitGnt(1);
      checkVal("cbLo grants with no credit", 32'(gntCount[4]), 32'(DEPTH));

      // Deferred returns restore one credit per cycle
      clearCounts();
      repeat (3) begin
         stepCycle();
         respCrdRet <= 1'b1;
      end
      waitGnt(4);
      repeat (10) stepCycle();
      checkVal("cbLo grants after response returns", 32'(gntCount[4]), 32'd3);
      keepMask = '0;
      @(posedge clk);
      pV <= '0;
      waitCreditsFull();

      // Conflict and DMA blocking
      echoRet = 1'b1;
      fixIds = 1'b1;
      keepMask = '1;
      @(posedge clk);
      for (int s = 0; s < 5; s++) begin
         pId[s] <= tlbIdT'(5);
      end
      pV <= '1;
      blkTlbId <= tlbIdT'(5);
      blkValid <= 1'b1;
      blkIsFill <= 1'b1;
      clearCounts();
      repeat (20) stepCycle();
      checkVal("translations under fill block",
               32'(gntCount[2] + gntCount[3] + gntCount[4]), 32'd0);
      checkVal("fill granted under fill block", 32'(gntCount[1] != 0), 32'd1);
      blkIsFill <= 1'b0;
      blkIsInval <= 1'b1;
      clearCounts();
      repeat (20) stepCycle();
      checkVal("translations under inval block",
               32'(gntCount[2] + gntCount[3] + gntCount[4]), 32'd0);
      checkVal("fill under inval block", 32'(gntCount[1]), 32'd0);
      checkVal("inv granted under inval block", 32'(gntCount[0] != 0), 32'd1);
      blkValid <= 1'b0;
      blkIsInval <= 1'b0;
      invBlockDma <= 1'b1;
      clearCounts();
      repeat (20) stepCycle();
      checkVal("translations under DMA block",
               32'(gntCount[2] + gntCount[3] + gntCount[4]), 32'd0);
      checkVal("fill granted under DMA block", 32'(gntCount[1] != 0), 32'd1);
      invBlockDma <= 1'b0;
      keepMask = '0;
      fixIds = 1'b0;
      @(posedge clk);
      pV <= '0;
      waitCreditsFull();

      // ====================
      // Random traffic against the model
      for (int c = 0; c < 2000; c++) begin
         @(posedge clk);
         if (c % 500 == 0) begin
            gcFill <= randGCnt();
            gcPendQ <= randGCnt();
            gcHi <= randGCnt();
            gcLo <= randGCnt();
         end
         for (int s = 0; s < 5; s++) begin
            // A waiting source keeps its payload
            if (!pV[s] || gntSeen[s]) begin
               pV[s] <= ($random(seed) & 3) != 0;
               pId[s] <= randId();
               pAddr[s] <= pageAddrT'($random(seed));
               pOp[s] <= randOp();
            end
         end
         outstanding = DEPTH - mCrd - mAcc;
         r = $random(seed) & 3;
         msfifoCrdRet <= (outstanding > 0) && (r == 0);
         respCrdRet <= (outstanding > 0) && (r == 1);
         blkValid <= ($random(seed) & 3) == 0;
         blkTlbId <= randId();
         blkIsFill <= ($random(seed) & 1) != 0;
         blkIsInval <= ($random(seed) & 1) != 0;
         invBlockDma <= ($random(seed) & 7) == 0;
      end
      @(posedge clk);
      pV <= '0;
      msfifoCrdRet <= 1'b0;
      respCrdRet <= 1'b0;
      blkValid <= 1'b0;
      invBlockDma <= 1'b0;
      keepMask = '0;
      echoRet = 1'b0;
      repeat (5) stepCycle();

      if (errCount == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
